/* logic/mist_core.sv */
`timescale 1ns/1ps

module mist_core #(
    parameter int rom_aw   = 4,
    parameter int h_active = 16,
    parameter int h_total  = 32,
    parameter int v_active = 8,
    parameter int v_total  = 12
) (
    input  logic             clk27,
    input  logic             rst_n,
    input  logic             spi_sck,
    input  logic             spi_ss2,
    input  logic             spi_di,
    output logic             led,
    output logic             downloading,
    output logic             pxl_cen,
    output logic             hs,
    output logic             vs,
    output mist_pkg::color_t red,
    output mist_pkg::color_t green,
    output mist_pkg::color_t blue,
    output mist_pkg::frame_t frame_cnt
);

    logic              ioctl_wr;
    mist_pkg::ioaddr_t ioctl_addr;
    mist_pkg::byte_t   ioctl_data;
    logic [rom_aw-1:0] rd_addr;
    mist_pkg::word_t   rd_data;
    logic              busy;

    spi_ioctl_decode u_decode (
        .clk27       ( clk27       ),
        .rst_n       ( rst_n       ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  )
    );

    rom_loader #(
        .rom_aw      ( rom_aw      )
    ) u_loader (
        .clk27       ( clk27       ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .rd_addr     ( rd_addr     ),
        .rd_data     ( rd_data     ),
        .busy        ( busy        )
    );

    video_scan #(
        .rom_aw      ( rom_aw      ),
        .h_active    ( h_active    ),
        .h_total     ( h_total     ),
        .v_active    ( v_active    ),
        .v_total     ( v_total     )
    ) u_scan (
        .clk27       ( clk27       ),
        .rst_n       ( rst_n       ),
        .busy        ( busy        ),
        .rd_data     ( rd_data     ),
        .rd_addr     ( rd_addr     ),
        .pxl_cen     ( pxl_cen     ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .frame_cnt   ( frame_cnt   )
    );

    // led goes dark while the ROM is loading
    assign led = ~busy;

endmodule

/* logic/mist_pkg.sv */
package mist_pkg;

    // one download byte as it arrives over SPI
    typedef logic [7:0] byte_t;

    // one ROM buffer word
    // red in 11:8, green in 7:4, blue in 3:0, top nibble unused
    typedef logic [15:0] word_t;

    // a single colour channel
    typedef logic [3:0] color_t;

    // byte address on the ioctl side, same width as the MiST firmware uses
    typedef logic [21:0] ioaddr_t;

    // free running frame counter
    typedef logic [31:0] frame_t;

    // command byte that opens a ROM download frame
    localparam byte_t cmd_download = 8'h54;

endpackage

/* logic/rom_loader.sv */
`timescale 1ns/1ps

module rom_loader #(
    parameter int rom_aw = 4
) (
    input  logic              clk27,
    input  logic              rst_n,
    input  logic              downloading,
    input  logic              ioctl_wr,
    input  mist_pkg::ioaddr_t ioctl_addr,
    input  mist_pkg::byte_t   ioctl_data,
    input  logic [rom_aw-1:0] rd_addr,
    output mist_pkg::word_t   rd_data,
    output logic              busy
);

    mist_pkg::word_t   mem [2**rom_aw];

    // low byte waiting for its partner
    mist_pkg::byte_t   lo_byte;
    logic [rom_aw-1:0] lo_addr;
    logic              lo_valid;

    logic              dl_last;
    logic              dl_fall;
    logic              pair_wr;
    logic              flush_wr;
    logic              mem_we;
    logic [rom_aw-1:0] wr_addr;
    mist_pkg::word_t   wr_word;

    assign dl_fall  = dl_last & ~downloading;
    assign pair_wr  = ioctl_wr & ioctl_addr[0];
    // odd length image, the last byte still sits in lo_byte
    assign flush_wr = dl_fall & lo_valid;
    assign mem_we   = pair_wr | flush_wr;

    assign wr_addr  = flush_wr ? lo_addr : ioctl_addr[rom_aw:1];
    assign wr_word  = flush_wr ? {8'h00, lo_byte} : {ioctl_data, lo_byte};

    // stays up for the flush cycle after downloading drops
    assign busy     = downloading | dl_last;

    always_ff @(posedge clk27) begin
        if (!rst_n) begin
            dl_last  <= 1'b0;
            lo_valid <= 1'b0;
        end else begin
            dl_last <= downloading;
            if (ioctl_wr && !ioctl_addr[0]) begin
                lo_valid <= 1'b1;
            end else if (mem_we) begin
                lo_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk27) begin
        if (ioctl_wr && !ioctl_addr[0]) begin
            lo_byte <= ioctl_data;
            lo_addr <= ioctl_addr[rom_aw:1];
        end
    end

    // buffer with one write port and a registered read port
    always_ff @(posedge clk27) begin
        if (mem_we) begin
            mem[wr_addr] <= wr_word;
        end
        rd_data <= mem[rd_addr];
    end

    a_write_when_busy: assert property (
        @(posedge clk27) disable iff (!rst_n) mem_we |-> busy
    );

endmodule

/* logic/spi_ioctl_decode.sv */
`timescale 1ns/1ps

module spi_ioctl_decode (
    input  logic              clk27,
    input  logic              rst_n,
    input  logic              spi_sck,
    input  logic              spi_ss2,
    input  logic              spi_di,
    output logic              downloading,
    output logic              ioctl_wr,
    output mist_pkg::ioaddr_t ioctl_addr,
    output mist_pkg::byte_t   ioctl_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_command,
        st_data,
        st_ignore
    } spi_state_t;

    spi_state_t      state;

    // pin synchronizers, bit 1 is the usable copy
    logic [1:0]      sck_sync;
    logic [1:0]      ss_sync;
    logic [1:0]      di_sync;
    logic            sck_last;
    logic            sck_rise;

    logic [2:0]      bit_cnt;
    logic [6:0]      shift;
    mist_pkg::byte_t rx_byte;
    logic            byte_done;

    always_ff @(posedge clk27) begin
        if (!rst_n) begin
            sck_sync <= 2'b00;
            ss_sync  <= 2'b11;
            di_sync  <= 2'b00;
            sck_last <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], spi_sck};
            ss_sync  <= {ss_sync[0], spi_ss2};
            di_sync  <= {di_sync[0], spi_di};
            sck_last <= sck_sync[1];
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_last;
    // byte as it stands once the current bit is taken in, msb first
    assign rx_byte   = {shift, di_sync[1]};
    assign byte_done = sck_rise && (bit_cnt == 3'd7) && (state != st_idle);

    // bit counter restarts whenever no frame is open
    always_ff @(posedge clk27) begin
        if (!rst_n) begin
            bit_cnt <= 3'd0;
        end else if (state == st_idle) begin
            bit_cnt <= 3'd0;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk27) begin
        if (sck_rise) begin
            shift <= rx_byte[6:0];
        end
        if (byte_done) begin
            ioctl_data <= rx_byte;
        end
    end

    always_ff @(posedge clk27) begin
        if (!rst_n) begin
            state       <= st_idle;
            downloading <= 1'b0;
            ioctl_wr    <= 1'b0;
            ioctl_addr  <= '0;
        end else begin
            ioctl_wr <= 1'b0;
            // address moves on once the write has been seen
            if (ioctl_wr) begin
                ioctl_addr <= ioctl_addr + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (!ss_sync[1]) begin
                        state      <= st_command;
                        ioctl_addr <= '0;
                    end
                end
                st_command: begin
                    if (ss_sync[1]) begin
                        state <= st_idle;
                    end else if (byte_done) begin
                        if (rx_byte == mist_pkg::cmd_download) begin
                            state       <= st_data;
                            downloading <= 1'b1;
                        end else begin
                            state <= st_ignore;
                        end
                    end
                end
                st_data: begin
                    if (ss_sync[1]) begin
                        state       <= st_idle;
                        downloading <= 1'b0;
                    end else if (byte_done) begin
                        ioctl_wr <= 1'b1;
                    end
                end
                st_ignore: begin
                    // unknown command, wait for the frame to close
                    if (ss_sync[1]) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_wr_in_download: assert property (
        @(posedge clk27) disable iff (!rst_n) ioctl_wr |-> downloading
    );

endmodule

/* logic/video_scan.sv */
`timescale 1ns/1ps

module video_scan #(
    parameter int rom_aw   = 4,
    parameter int h_active = 16,
    parameter int h_total  = 32,
    parameter int v_active = 8,
    parameter int v_total  = 12
) (
    input  logic              clk27,
    input  logic              rst_n,
    input  logic              busy,
    input  mist_pkg::word_t   rd_data,
    output logic [rom_aw-1:0] rd_addr,
    output logic              pxl_cen,
    output logic              hs,
    output logic              vs,
    output mist_pkg::color_t  red,
    output mist_pkg::color_t  green,
    output mist_pkg::color_t  blue,
    output mist_pkg::frame_t  frame_cnt
);

    localparam int h_fp = 4;
    localparam int h_sw = 4;
    localparam int v_fp = 1;
    localparam int v_sw = 2;

    localparam int hw = $clog2(h_total);
    localparam int vw = $clog2(v_total);

    localparam logic [hw-1:0] h_last   = hw'(h_total - 1);
    localparam logic [hw-1:0] h_act_n  = hw'(h_active);
    localparam logic [hw-1:0] hs_start = hw'(h_active + h_fp);
    localparam logic [hw-1:0] hs_end   = hw'(h_active + h_fp + h_sw);
    localparam logic [vw-1:0] v_last   = vw'(v_total - 1);
    localparam logic [vw-1:0] v_act_n  = vw'(v_active);
    localparam logic [vw-1:0] vs_start = vw'(v_active + v_fp);
    localparam logic [vw-1:0] vs_end   = vw'(v_active + v_fp + v_sw);

    logic [hw-1:0] h_cnt;
    logic [vw-1:0] v_cnt;
    logic          de_next;
    logic          hs_next;
    logic          vs_next;
    logic          de;

    // word for pixel h is requested in the cycle before its pxl_cen
    assign rd_addr = rom_aw'(h_cnt);

    assign de_next = (h_cnt < h_act_n) && (v_cnt < v_act_n);
    assign hs_next = (h_cnt >= hs_start) && (h_cnt < hs_end);
    assign vs_next = (v_cnt >= vs_start) && (v_cnt < vs_end);

    always_ff @(posedge clk27) begin
        if (!rst_n) begin
            pxl_cen   <= 1'b0;
            h_cnt     <= '0;
            v_cnt     <= '0;
            de        <= 1'b0;
            hs        <= 1'b0;
            vs        <= 1'b0;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
            frame_cnt <= '0;
        end else begin
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                if (h_cnt == h_last) begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
                // all pixel outputs move together
                de <= de_next;
                hs <= hs_next;
                vs <= vs_next;
                if (de_next && !busy) begin
                    red   <= rd_data[11:8];
                    green <= rd_data[7:4];
                    blue  <= rd_data[3:0];
                end else begin
                    red   <= '0;
                    green <= '0;
                    blue  <= '0;
                end
                if (vs_next && !vs) begin
                    frame_cnt <= frame_cnt + 32'd1;
                end
            end
        end
    end

    a_sync_in_blank: assert property (
        @(posedge clk27) disable iff (!rst_n) de |-> (!hs && !vs)
    );

    a_black_in_blank: assert property (
        @(posedge clk27) disable iff (!rst_n) !de |-> ({red, green, blue} == '0)
    );

endmodule

/* sources.f */
+incdir+include
logic/mist_pkg.sv
logic/spi_ioctl_decode.sv
logic/rom_loader.sv
logic/video_scan.sv
logic/mist_core.sv
test/mist_test.sv

/* include/mist_tb_tasks.svh */
`ifndef MIST_TB_TASKS_SVH
`define MIST_TB_TASKS_SVH

// prints the error line and stops the run
task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1);
endtask

// waits n rising edges and steps 1 ns past the last one
task automatic hold(input int n);
    repeat (n) @(posedge clk27);
    #1;
endtask

// one byte msb first with each SPI level held 4 clocks
task automatic spi_byte(input mist_pkg::byte_t b);
    for (int i = 7; i >= 0; i--) begin
        spi_di = b[i];
        hold(4);
        spi_sck = 1'b1;
        hold(4);
        spi_sck = 1'b0;
    end
    hold(4);
endtask

// opens a frame and sends the command and the first n image bytes
task automatic send_frame(input mist_pkg::byte_t cmd, input int n);
    spi_ss2 = 1'b0;
    hold(4);
    spi_byte(cmd);
    for (int i = 0; i < n; i++) begin
        spi_byte(img_bytes[i]);
    end
endtask

task automatic close_frame();
    spi_ss2 = 1'b1;
    hold(8);
endtask

// expected ROM words from low-first byte pairs and an odd tail with a zero high half
function automatic void build_expected_words(input int n);
    for (int i = 1; i < n; i += 2) begin
        exp_words[(i / 2) % rom_words] = {img_bytes[i], img_bytes[i - 1]};
    end
    if (n % 2 == 1) begin
        exp_words[((n - 1) / 2) % rom_words] = {8'h00, img_bytes[n - 1]};
    end
endfunction

// stops at the next negedge that falls inside a pxl_cen cycle
task automatic next_pixel();
    @(negedge clk27);
    while (pxl_cen !== 1'b1) begin
        @(negedge clk27);
    end
endtask

// finds the first line after vs and then the sample after hs falls
task automatic align_to_sync();
    logic prev;
    prev = 1'b0;
    next_pixel();
    while (!(prev === 1'b1 && vs === 1'b0)) begin
        prev = vs;
        next_pixel();
    end
    prev = 1'b0;
    while (!(prev === 1'b1 && hs === 1'b0)) begin
        prev = hs;
        next_pixel();
    end
    pos_h = h_active + h_fp + h_sw;
    pos_v = v_active + v_fp + v_sw;
endtask

// compares the current sample with position pos_h and pos_v and moves on
task automatic check_pixel(input bit check_active);
    logic            exp_hs;
    logic            exp_vs;
    logic            active;
    mist_pkg::word_t w;
    exp_hs = (pos_h >= h_active + h_fp) && (pos_h < h_active + h_fp + h_sw);
    exp_vs = (pos_v >= v_active + v_fp) && (pos_v < v_active + v_fp + v_sw);
    active = (pos_h < h_active) && (pos_v < v_active);
    w = active ? exp_words[pos_h % rom_words] : 16'h0000;
    assert (hs === exp_hs && vs === exp_vs) else
        report_error($sformatf("hs=%b vs=%b at h=%0d v=%0d, expected hs=%b vs=%b",
                               hs, vs, pos_h, pos_v, exp_hs, exp_vs));
    if (check_active || !active) begin
        assert ({red, green, blue} === w[11:0]) else
            report_error($sformatf("colour %h at h=%0d v=%0d, expected %h",
                                   {red, green, blue}, pos_h, pos_v, w[11:0]));
    end
    if (pos_h == h_total - 1) begin
        pos_h = 0;
        pos_v = (pos_v == v_total - 1) ? 0 : pos_v + 1;
    end else begin
        pos_h = pos_h + 1;
    end
endtask

`endif

/* test/mist_test.sv */
`timescale 1ns/1ps

module mist_test;

    localparam int h_active = 16;
    localparam int h_total = 32;
    localparam int v_active = 8;
    localparam int v_total = 12;
    localparam int h_fp = 4;
    localparam int h_sw = 4;
    localparam int v_fp = 1;
    localparam int v_sw = 2;
    localparam int rom_words = 16;
    localparam int frame_pixels = h_total * v_total;
    // about 4800 cycles of SPI traffic and 8 frame scans of 768 cycles leave headroom
    localparam int timeout_cycles = 20000;

    logic             clk27;
    logic             rst_n;
    logic             spi_sck;
    logic             spi_ss2;
    logic             spi_di;
    logic             led;
    logic             downloading;
    logic             pxl_cen;
    logic             hs;
    logic             vs;
    mist_pkg::color_t red;
    mist_pkg::color_t green;
    mist_pkg::color_t blue;
    mist_pkg::frame_t frame_cnt;

    mist_pkg::byte_t  img_bytes [0:32];
    mist_pkg::word_t  exp_words [0:rom_words-1];
    int               pos_h;
    int               pos_v;
    int               cycle_count;
    int               blank_checks;
    logic             monitor_on;
    logic             prev_busy;
    logic             dl_seen;

    mist_core uut (
        .clk27       ( clk27       ),
        .rst_n       ( rst_n       ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .led         ( led         ),
        .downloading ( downloading ),
        .pxl_cen     ( pxl_cen     ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .frame_cnt   ( frame_cnt   )
    );

    `include "mist_tb_tasks.svh"

    always #4 clk27 = ~clk27;

    always @(posedge clk27) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // a pixel produced while led was low must be black
    always @(negedge clk27) begin
        if (downloading === 1'b1) begin
            dl_seen = 1'b1;
        end
        if (monitor_on && pxl_cen === 1'b1) begin
            if (prev_busy) begin
                assert ({red, green, blue} === 12'h000) else
                    report_error($sformatf("colour %h during a download", {red, green, blue}));
                blank_checks = blank_checks + 1;
            end
            prev_busy = (led === 1'b0);
        end
    end

    task automatic verify_reset_state();
        @(negedge clk27);
        assert (downloading === 1'b0 && hs === 1'b0 && vs === 1'b0) else
            report_error("downloading or a sync is not low after reset");
        assert ({red, green, blue} === 12'h000) else
            report_error($sformatf("colour %h after reset", {red, green, blue}));
        assert (led === 1'b1 && frame_cnt === 32'd0) else
            report_error($sformatf("led=%b frame_cnt=%0d after reset", led, frame_cnt));
        // pixel enable is low in the first cycle after reset and then alternates
        for (int i = 0; i < 4; i++) begin
            assert (pxl_cen === ((i % 2) == 1)) else
                report_error($sformatf("pxl_cen=%b in cycle %0d after reset", pxl_cen, i + 1));
            @(negedge clk27);
        end
    endtask

    task automatic measure_video_timing();
        int               hs_count;
        int               vs_count;
        int               vs_rises;
        logic             vs_prev;
        mist_pkg::frame_t start_cnt;
        hs_count = 0;
        vs_count = 0;
        vs_rises = 0;
        align_to_sync();
        vs_prev = vs;
        start_cnt = frame_cnt;
        for (int i = 0; i < 3 * frame_pixels; i++) begin
            if (hs === 1'b1) begin
                hs_count++;
            end
            if (vs === 1'b1) begin
                vs_count++;
            end
            if (vs === 1'b1 && vs_prev === 1'b0) begin
                vs_rises++;
            end
            vs_prev = vs;
            check_pixel(1'b0);
            next_pixel();
        end
        assert (hs_count == 3 * v_total * h_sw) else
            report_error($sformatf("%0d hs samples in 3 frames", hs_count));
        assert (vs_count == 3 * v_sw * h_total) else
            report_error($sformatf("%0d vs samples in 3 frames", vs_count));
        assert (vs_rises == 3 && frame_cnt - start_cnt == 32'd3) else
            report_error($sformatf("frame_cnt moved by %0d over %0d vs pulses",
                                   frame_cnt - start_cnt, vs_rises));
    endtask

    task automatic ignored_command_frame();
        dl_seen = 1'b0;
        send_frame(8'h12, 2);
        close_frame();
        assert (!dl_seen && led === 1'b1) else
            report_error("a frame with another command raised downloading");
    endtask

    task automatic download_image(input int n);
        blank_checks = 0;
        send_frame(mist_pkg::cmd_download, n);
        assert (downloading === 1'b1 && led === 1'b0) else
            report_error($sformatf("downloading=%b led=%b inside a download", downloading, led));
        close_frame();
        assert (downloading === 1'b0 && led === 1'b1) else
            report_error($sformatf("downloading=%b led=%b after the frame", downloading, led));
        assert (blank_checks > 0) else
            report_error("no pixel was sampled while the download was running");
        build_expected_words(n);
    endtask

    task automatic compare_image();
        align_to_sync();
        for (int i = 0; i < frame_pixels; i++) begin
            check_pixel(1'b1);
            next_pixel();
        end
    endtask

    initial begin
        clk27 = 1'b0;
        rst_n = 1'b0;
        spi_sck = 1'b0;
        spi_ss2 = 1'b1;
        spi_di = 1'b0;
        cycle_count = 0;
        blank_checks = 0;
        monitor_on = 1'b0;
        prev_busy = 1'b0;
        dl_seen = 1'b0;
        pos_h = 0;
        pos_v = 0;
        void'($urandom(31091));
        for (int i = 0; i < 33; i++) begin
            img_bytes[i] = mist_pkg::byte_t'($urandom());
        end
        // the tail byte has to differ from a blank word
        if (img_bytes[32] == 8'h00) begin
            img_bytes[32] = 8'ha5;
        end
        repeat (4) @(posedge clk27);
        #1;
        rst_n = 1'b1;
        verify_reset_state();
        monitor_on = 1'b1;
        measure_video_timing();
        ignored_command_frame();
        download_image(32);
        compare_image();
        // wraps onto word 0 with an odd tail
        download_image(33);
        compare_image();
        $display("Finished with no errors");
        $finish;
    end

endmodule
